// File: hw/dither_defs.svh
`ifndef DITHER_DEFS_SVH
`define DITHER_DEFS_SVH

// largest image side, in pixels
`define DITHER_MAX_SIDE 16

// one grey pixel per byte
`define DITHER_PIX_W 8

// 16 x 16 pixels fit in 256 words
`define DITHER_ADDR_W 8

// grey level at or above this turns white
`define DITHER_THRESH 128

// width, height, algorithm
`define DITHER_HDR_BYTES 3

`endif

// File: hw/dither_pkg.sv
`default_nettype none

`include "dither_defs.svh"

package dither_pkg;

    // frame sequence seen by the SPI port
    typedef enum logic [1:0] {
        PH_HEADER,
        PH_LOAD,
        PH_PROCESS,
        PH_SEND
    } phase_t;

    // header byte 2, any code above 2 means full floyd-steinberg
    typedef enum logic [1:0] {
        ALGO_THRESH      = 2'd0,
        ALGO_SIERRA_LITE = 2'd1,
        ALGO_FS_REDUCED  = 2'd2,
        ALGO_FLOYD       = 2'd3
    } algo_t;

    // sides already clamped to 1..16
    typedef struct packed {
        logic [4:0] width;
        logic [4:0] height;
        algo_t      algo;
    } frame_cfg_t;

    // read whenever wen is low
    typedef struct packed {
        logic [`DITHER_ADDR_W-1:0] addr;
        logic [`DITHER_PIX_W-1:0]  wdata;
        logic                      wen;
    } ram_req_t;

endpackage

`default_nettype wire

// File: hw/dither_top.sv
`timescale 1ns/10ps
`default_nettype none

module dither_top
    import dither_pkg::*;
(
    input  wire logic SPI_CLK,
    input  wire logic rst,
    input  wire logic spi_cs,
    input  wire logic spi_mosi,
    output logic      spi_miso,
    output logic      frame_ready
);

    frame_cfg_t cfg;
    logic [8:0] pixel_count;
    logic       hdr_strobe;
    logic [7:0] hdr_byte;
    logic [1:0] hdr_index;
    ram_req_t   host_req;
    ram_req_t   eng_req;
    logic       host_sel;
    logic [7:0] ram_rdata;
    logic       start;
    logic       done;

    // header bytes into frame size and kernel
    header_regs hdr0 (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .hdr_strobe  (hdr_strobe),
        .hdr_byte    (hdr_byte),
        .hdr_index   (hdr_index),
        .cfg         (cfg),
        .pixel_count (pixel_count)
    );

    // serial side and frame sequencing
    spi_frame_port port0 (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .frame_ready (frame_ready),
        .hdr_strobe  (hdr_strobe),
        .hdr_byte    (hdr_byte),
        .hdr_index   (hdr_index),
        .pixel_count (pixel_count),
        .host_req    (host_req),
        .host_sel    (host_sel),
        .ram_rdata   (ram_rdata),
        .start       (start),
        .done        (done)
    );

    pixel_ram ram0 (
        .SPI_CLK  (SPI_CLK),
        .host_req (host_req),
        .eng_req  (eng_req),
        .host_sel (host_sel),
        .rdata    (ram_rdata)
    );

    // in-place dithering engine
    error_diffuser diff0 (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .start       (start),
        .cfg         (cfg),
        .pixel_count (pixel_count),
        .eng_req     (eng_req),
        .ram_rdata   (ram_rdata),
        .done        (done)
    );

endmodule

`default_nettype wire

// File: hw/error_diffuser.sv
`timescale 1ns/10ps
`default_nettype none

`include "dither_defs.svh"

module error_diffuser
    import dither_pkg::*;
(
    input  wire logic       SPI_CLK,
    input  wire logic       rst,
    input  wire logic       start,
    input  wire frame_cfg_t cfg,
    input  wire logic [8:0] pixel_count,
    output ram_req_t        eng_req,
    input  wire logic [7:0] ram_rdata,
    output logic            done
);

    // neighbour slots, one read/write pair each
    localparam logic [2:0] SLOT_C  = 3'd0;
    localparam logic [2:0] SLOT_E  = 3'd1;
    localparam logic [2:0] SLOT_SW = 3'd2;
    localparam logic [2:0] SLOT_S  = 3'd3;
    localparam logic [2:0] SLOT_SE = 3'd4;

    logic               busy;
    logic        [3:0]  step;
    logic        [2:0]  slot;
    logic        [3:0]  col;
    logic        [3:0]  row;
    logic        [7:0]  pix_addr;
    logic        [7:0]  width8;
    logic        [7:0]  slot_addr;
    logic               slot_valid;
    logic               last_col;
    logic               first_col;
    logic               last_row;
    logic               last_pix;
    logic        [2:0]  weight;
    logic        [2:0]  shift;
    logic        [7:0]  new_pix;
    logic signed [8:0]  err;
    logic signed [11:0] prod;
    logic signed [11:0] delta;
    logic signed [11:0] sum;
    logic        [7:0]  upd_pix;

    // even step reads, odd step writes the same slot
    assign slot      = step[3:1];
    assign width8    = {3'b000, cfg.width};
    assign last_col  = ({1'b0, col} == cfg.width - 5'd1);
    assign first_col = (col == 4'd0);
    assign last_row  = ({1'b0, row} == cfg.height - 5'd1);
    assign last_pix  = ({1'b0, pix_addr} == pixel_count - 9'd1);
    assign done      = busy && (step == 4'd9) && last_pix;

    // raster sweep, 10 cycles a pixel
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step     <= '0;
            col      <= '0;
            row      <= '0;
            pix_addr <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            step     <= '0;
            col      <= '0;
            row      <= '0;
            pix_addr <= '0;
        end else if (busy) begin
            if (step == 4'd9) begin
                step     <= '0;
                pix_addr <= pix_addr + 8'd1;
                if (last_pix) begin
                    busy <= 1'b0;
                end
                if (last_col) begin
                    col <= '0;
                    row <= row + 4'd1;
                end else begin
                    col <= col + 4'd1;
                end
            end else begin
                step <= step + 4'd1;
            end
        end
    end

    // neighbour address and edge test
    always_comb begin
        slot_addr  = pix_addr;
        slot_valid = 1'b1;
        case (slot)
            SLOT_E: begin
                slot_addr  = pix_addr + 8'd1;
                slot_valid = !last_col;
            end
            SLOT_SW: begin
                slot_addr  = pix_addr + width8 - 8'd1;
                slot_valid = !first_col && !last_row;
            end
            SLOT_S: begin
                slot_addr  = pix_addr + width8;
                slot_valid = !last_row;
            end
            SLOT_SE: begin
                slot_addr  = pix_addr + width8 + 8'd1;
                slot_valid = !last_col && !last_row;
            end
            default: ;
        endcase
    end

    // kernel weight and shift for the current slot
    always_comb begin
        weight = 3'd0;
        shift  = 3'd0;
        case (cfg.algo)
            ALGO_SIERRA_LITE: begin
                shift = 3'd2;
                case (slot)
                    SLOT_E:  weight = 3'd2;
                    SLOT_SW: weight = 3'd1;
                    SLOT_S:  weight = 3'd1;
                    default: weight = 3'd0;
                endcase
            end
            ALGO_FS_REDUCED: begin
                shift = 3'd3;
                case (slot)
                    SLOT_E:  weight = 3'd3;
                    SLOT_S:  weight = 3'd3;
                    SLOT_SE: weight = 3'd2;
                    default: weight = 3'd0;
                endcase
            end
            ALGO_FLOYD: begin
                shift = 3'd4;
                case (slot)
                    SLOT_E:  weight = 3'd7;
                    SLOT_SW: weight = 3'd3;
                    SLOT_S:  weight = 3'd5;
                    SLOT_SE: weight = 3'd1;
                    default: weight = 3'd0;
                endcase
            end
            // plain threshold spreads nothing
            default: ;
        endcase
    end

    assign new_pix = (ram_rdata >= 8'(`DITHER_THRESH)) ? 8'hFF : 8'h00;

    // signed error, kept for the four neighbours
    always_ff @(posedge SPI_CLK) begin
        if (busy && (step == 4'd1)) begin
            err <= $signed({1'b0, ram_rdata}) - $signed({1'b0, new_pix});
        end
    end

    // neighbour update, arithmetic shift then clamp to a byte
    always_comb begin
        prod  = err * $signed({1'b0, weight});
        delta = prod >>> shift;
        sum   = $signed({4'b0000, ram_rdata}) + delta;
        if (sum < 0) begin
            upd_pix = 8'h00;
        end else if (sum > 12'sd255) begin
            upd_pix = 8'hFF;
        end else begin
            upd_pix = sum[7:0];
        end
    end

    always_comb begin
        eng_req.addr  = slot_addr;
        eng_req.wdata = (slot == SLOT_C) ? new_pix : upd_pix;
        // out-of-image and zero-weight slots keep their cycles, no write
        eng_req.wen   = busy && step[0] && slot_valid && ((slot == SLOT_C) || (weight != 3'd0));
    end

endmodule

`default_nettype wire

// File: hw/header_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "dither_defs.svh"

module header_regs
    import dither_pkg::*;
(
    input  wire logic       SPI_CLK,
    input  wire logic       rst,
    input  wire logic       hdr_strobe,
    input  wire logic [7:0] hdr_byte,
    input  wire logic [1:0] hdr_index,
    output frame_cfg_t      cfg,
    output logic      [8:0] pixel_count
);

    logic [4:0] side;

    // zero becomes 1, anything past the max side saturates
    always_comb begin
        if (hdr_byte == 8'd0) begin
            side = 5'd1;
        end else if (hdr_byte > 8'(`DITHER_MAX_SIDE)) begin
            side = 5'(`DITHER_MAX_SIDE);
        end else begin
            side = hdr_byte[4:0];
        end
    end

    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            cfg         <= '{width: 5'd1, height: 5'd1, algo: ALGO_THRESH};
            pixel_count <= 9'd1;
        end else if (hdr_strobe) begin
            case (hdr_index)
                2'd0: cfg.width <= side;
                2'd1: begin
                    cfg.height  <= side;
                    // width already latched one byte earlier
                    pixel_count <= {4'b0000, cfg.width} * {4'b0000, side};
                end
                2'd2: begin
                    case (hdr_byte)
                        8'd0:    cfg.algo <= ALGO_THRESH;
                        8'd1:    cfg.algo <= ALGO_SIERRA_LITE;
                        8'd2:    cfg.algo <= ALGO_FS_REDUCED;
                        default: cfg.algo <= ALGO_FLOYD;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "dither_defs.svh"

module pixel_ram
    import dither_pkg::*;
(
    input  wire logic     SPI_CLK,
    input  wire ram_req_t host_req,
    input  wire ram_req_t eng_req,
    input  wire logic     host_sel,
    output logic    [7:0] rdata
);

    logic [`DITHER_PIX_W-1:0] mem [0:(2**`DITHER_ADDR_W)-1];
    ram_req_t                 req;

    // one request owns the array each cycle
    assign req = host_sel ? host_req : eng_req;

    // registered read, old data on a same-address write
    always_ff @(posedge SPI_CLK) begin
        if (req.wen) begin
            mem[req.addr] <= req.wdata;
        end
        rdata <= mem[req.addr];
    end

endmodule

`default_nettype wire

// File: hw/spi_frame_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "dither_defs.svh"

module spi_frame_port
    import dither_pkg::*;
(
    input  wire logic       SPI_CLK,
    input  wire logic       rst,
    input  wire logic       spi_cs,
    input  wire logic       spi_mosi,
    output logic            spi_miso,
    output logic            frame_ready,
    output logic            hdr_strobe,
    output logic      [7:0] hdr_byte,
    output logic      [1:0] hdr_index,
    input  wire logic [8:0] pixel_count,
    output ram_req_t        host_req,
    output logic            host_sel,
    input  wire logic [7:0] ram_rdata,
    output logic            start,
    input  wire logic       done
);

    phase_t     phase;
    logic [2:0] bit_cnt;
    logic [1:0] hdr_cnt;
    logic [8:0] byte_cnt;
    logic [8:0] last_idx;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       ld_wen;
    logic       fetch0;
    logic       fetch1;
    logic       shift_en;
    logic       byte_end;

    // host has no say while the engine runs
    assign shift_en = ~spi_cs && (phase != PH_PROCESS);
    assign byte_end = shift_en && (bit_cnt == 3'd7);
    assign last_idx = pixel_count - 9'd1;

    assign hdr_byte = rx_shift;
    assign spi_miso = tx_shift[7];

    // RAM belongs to the host while loading, sending, or fetching pixel 0
    assign host_sel = (phase == PH_LOAD) || (phase == PH_SEND) || fetch0;

    always_comb begin
        host_req.addr  = byte_cnt[7:0];
        host_req.wdata = rx_shift;
        host_req.wen   = 1'b0;
        if (phase == PH_LOAD) begin
            host_req.wen = ld_wen;
        end else if (fetch0) begin
            host_req.addr = '0;
        end else if (phase == PH_SEND) begin
            // keep the next pixel on rdata ahead of its byte boundary
            host_req.addr = byte_cnt[7:0] + 8'd1;
        end
    end

    // mosi shifter, msb first
    always_ff @(posedge SPI_CLK) begin
        if (shift_en) begin
            rx_shift <= {rx_shift[6:0], spi_mosi};
        end
    end

    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            phase       <= PH_HEADER;
            bit_cnt     <= '0;
            hdr_cnt     <= '0;
            byte_cnt    <= '0;
            tx_shift    <= '0;
            hdr_strobe  <= 1'b0;
            hdr_index   <= '0;
            ld_wen      <= 1'b0;
            start       <= 1'b0;
            fetch0      <= 1'b0;
            fetch1      <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            hdr_strobe <= 1'b0;
            ld_wen     <= 1'b0;
            start      <= 1'b0;
            // done, then address 0, then data
            fetch0     <= done;
            fetch1     <= fetch0;
            if (shift_en) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
            case (phase)
                PH_HEADER: begin
                    if (byte_end) begin
                        hdr_strobe <= 1'b1;
                        hdr_index  <= hdr_cnt;
                        if (hdr_cnt == 2'(`DITHER_HDR_BYTES - 1)) begin
                            hdr_cnt  <= '0;
                            byte_cnt <= '0;
                            phase    <= PH_LOAD;
                        end else begin
                            hdr_cnt <= hdr_cnt + 2'd1;
                        end
                    end
                end
                PH_LOAD: begin
                    if (byte_end) begin
                        ld_wen <= 1'b1;
                    end
                    // write goes out this cycle
                    if (ld_wen) begin
                        byte_cnt <= byte_cnt + 9'd1;
                        if (byte_cnt == last_idx) begin
                            start   <= 1'b1;
                            bit_cnt <= '0;
                            phase   <= PH_PROCESS;
                        end
                    end
                end
                PH_PROCESS: begin
                    if (fetch1) begin
                        // pixel 0 bit 7 on miso as frame_ready rises
                        tx_shift    <= ram_rdata;
                        byte_cnt    <= '0;
                        frame_ready <= 1'b1;
                        phase       <= PH_SEND;
                    end
                end
                default: begin
                    if (byte_end) begin
                        if (byte_cnt == last_idx) begin
                            // last bit out, re-arm for the next header
                            tx_shift    <= '0;
                            frame_ready <= 1'b0;
                            phase       <= PH_HEADER;
                        end else begin
                            tx_shift <= ram_rdata;
                            byte_cnt <= byte_cnt + 9'd1;
                        end
                    end else if (shift_en) begin
                        tx_shift <= {tx_shift[6:0], 1'b0};
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the dithering testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module dither_tb -o dither_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/dither_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

// File: sources.f
+incdir+hw
hw/dither_pkg.sv
hw/header_regs.sv
hw/spi_frame_port.sv
hw/pixel_ram.sv
hw/error_diffuser.sv
hw/dither_top.sv
verif/dither_properties.sv
verif/dither_tb.sv

// File: verif/dither_properties.sv
`timescale 1ns/10ps
`default_nettype none

module dither_properties
    import dither_pkg::*;
(
    input wire logic   SPI_CLK,
    input wire logic   rst,
    input wire phase_t phase,
    input wire logic   frame_ready,
    input wire logic   spi_miso,
    input wire logic   start,
    input wire logic   eng_wen
);

    // result only offered while sending
    ready_in_send: assert property (
        @(posedge SPI_CLK) disable iff (rst)
        frame_ready |-> (phase == PH_SEND)
    ) else $error("frame_ready high outside PH_SEND");

    // engine touches the RAM only while processing
    eng_write_in_process: assert property (
        @(posedge SPI_CLK) disable iff (rst)
        eng_wen |-> (phase == PH_PROCESS)
    ) else $error("engine write outside PH_PROCESS");

    start_one_cycle: assert property (
        @(posedge SPI_CLK) disable iff (rst)
        start |=> !start
    ) else $error("start held for more than one cycle");

    // outputs quiet on reset release
    quiet_after_reset: assert property (
        @(posedge SPI_CLK)
        $fell(rst) |-> (!spi_miso && !frame_ready)
    ) else $error("spi_miso or frame_ready high after reset");

endmodule

// phase sits inside the SPI port, the rest at the top level
bind dither_top dither_properties props0 (
    .SPI_CLK     (SPI_CLK),
    .rst         (rst),
    .phase       (port0.phase),
    .frame_ready (frame_ready),
    .spi_miso    (spi_miso),
    .start       (start),
    .eng_wen     (eng_req.wen)
);

`default_nettype wire

// File: verif/dither_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dither_defs.svh"

module dither_tb;

    // engine needs 10 cycles a pixel plus the fetch of pixel 0
    localparam int DONE_LIMIT = 10 * 256 + 64;

    logic SPI_CLK;
    logic rst;
    logic spi_cs;
    logic spi_mosi;
    logic spi_miso;
    logic frame_ready;

    // expected frame dithered in place like the RAM
    int model_mem [0:255];
    int frames_run;

    dither_top dut0 (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .frame_ready (frame_ready)
    );

    // 40 ns period
    initial begin
        SPI_CLK = 1'b0;
        forever #20 SPI_CLK = ~SPI_CLK;
    end

    task automatic check_value(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("error %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    // zero turns into 1 and large sides saturate
    function automatic int clamp_side(input int raw);
        int side;
        side = raw;
        if (raw == 0) begin
            side = 1;
        end else if (raw > `DITHER_MAX_SIDE) begin
            side = `DITHER_MAX_SIDE;
        end
        return side;
    endfunction

    // called on a falling edge and returns on the next one after the bit shifted
    task automatic send_bit(input logic b, input bit gaps);
        int pause;
        pause = 0;
        if (gaps && ($urandom % 4 == 0)) begin
            pause = 1 + ($urandom % 3);
        end
        // cs high holds the shifter in place
        repeat (pause) begin
            spi_cs   = 1'b1;
            spi_mosi = ~b;
            @(negedge SPI_CLK);
        end
        spi_cs   = 1'b0;
        spi_mosi = b;
        @(negedge SPI_CLK);
    endtask

    task automatic send_byte(input logic [7:0] value, input bit gaps);
        int i;
        // msb first
        for (i = 7; i >= 0; i--) begin
            send_bit(value[i], gaps);
        end
    endtask

    task automatic recv_bit(input bit gaps, output logic b);
        int pause;
        pause = 0;
        if (gaps && ($urandom % 4 == 0)) begin
            pause = 1 + ($urandom % 3);
        end
        repeat (pause) begin
            spi_cs = 1'b1;
            @(negedge SPI_CLK);
        end
        // miso already shows the bit the next rising edge consumes
        b      = spi_miso;
        spi_cs = 1'b0;
        @(negedge SPI_CLK);
    endtask

    task automatic wait_frame_ready(input int limit);
        int cyc;
        for (cyc = 0; cyc < limit && !frame_ready; cyc++) begin
            @(negedge SPI_CLK);
        end
        if (!frame_ready) begin
            abort_run("frame_ready never rose after the frame was loaded");
        end
    endtask

    // raster sweep that thresholds and then spreads the error to E, SW, S and SE
    task automatic dither_model(input int w, input int h, input int algo);
        int wt [4];
        int dc [4];
        int dr [4];
        int shamt;
        int x;
        int y;
        int k;
        int p;
        int n;
        int nx;
        int ny;
        int old;
        int nv;
        int err;
        int sum;
        dc = '{1, -1, 0, 1};
        dr = '{0, 1, 1, 1};
        case (algo)
            0: begin
                wt    = '{0, 0, 0, 0};
                shamt = 0;
            end
            1: begin
                wt    = '{2, 1, 1, 0};
                shamt = 2;
            end
            2: begin
                wt    = '{3, 0, 3, 2};
                shamt = 3;
            end
            // every other code is full floyd-steinberg
            default: begin
                wt    = '{7, 3, 5, 1};
                shamt = 4;
            end
        endcase
        for (y = 0; y < h; y++) begin
            for (x = 0; x < w; x++) begin
                p   = y * w + x;
                old = model_mem[p];
                nv  = (old >= `DITHER_THRESH) ? 255 : 0;
                err = old - nv;
                model_mem[p] = nv;
                for (k = 0; k < 4; k++) begin
                    nx = x + dc[k];
                    ny = y + dr[k];
                    // neighbours outside the image are skipped
                    if (wt[k] != 0 && nx >= 0 && nx < w && ny < h) begin
                        n   = ny * w + nx;
                        sum = model_mem[n] + ((err * wt[k]) >>> shamt);
                        if (sum < 0) begin
                            sum = 0;
                        end else if (sum > 255) begin
                            sum = 255;
                        end
                        model_mem[n] = sum;
                    end
                end
            end
        end
    endtask

    task automatic run_frame(input int w_raw, input int h_raw, input int algo,
                             input int mode, input int arg, input bit gaps);
        int w;
        int h;
        int count;
        int i;
        int nbits;
        int idx;
        logic b;
        logic [7:0] got;
        w     = clamp_side(w_raw);
        h     = clamp_side(h_raw);
        count = w * h;
        got   = '0;
        // fill mode picks random, ramp or constant pixels
        for (i = 0; i < count; i++) begin
            case (mode)
                0:       model_mem[i] = $urandom % 256;
                1:       model_mem[i] = (i * arg) % 256;
                default: model_mem[i] = arg % 256;
            endcase
        end
        // header goes out unclamped for the DUT to clamp
        send_byte(8'(w_raw), gaps);
        send_byte(8'(h_raw), gaps);
        send_byte(8'(algo), gaps);
        for (i = 0; i < count; i++) begin
            send_byte(8'(model_mem[i]), gaps);
        end
        spi_cs = 1'b1;
        dither_model(w, h, algo);
        wait_frame_ready(DONE_LIMIT);
        nbits = 0;
        // one spare byte of room to catch a late fall of frame_ready
        for (i = 0; i < 8 * count + 8 && frame_ready; i++) begin
            recv_bit(gaps, b);
            got   = {got[6:0], b};
            nbits = nbits + 1;
            if (nbits % 8 == 0) begin
                idx = nbits / 8 - 1;
                if (idx < count) begin
                    check_value(int'(got), model_mem[idx],
                                $sformatf("frame %0d pixel %0d", frames_run, idx));
                end
            end
        end
        spi_cs = 1'b1;
        if (frame_ready) begin
            abort_run("frame_ready stayed high after the last expected byte");
        end
        check_value(nbits, 8 * count, $sformatf("frame %0d bits before frame_ready fell",
                                                frames_run));
    endtask

    initial begin
        int fd;
        int fields;
        int w_raw;
        int h_raw;
        int algo;
        int mode;
        int arg;
        int gaps;
        string line;
        void'($urandom(32'h6ffa21f8));
        rst        = 1'b1;
        spi_cs     = 1'b1;
        spi_mosi   = 1'b0;
        frames_run = 0;
        // reset spans three rising edges
        repeat (3) @(posedge SPI_CLK);
        @(negedge SPI_CLK);
        rst = 1'b0;
        @(negedge SPI_CLK);
        fd = $fopen("verif/dither_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open verif/dither_vectors.txt");
        end
        // frames run back to back and each one re-arms the unit
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%d %d %d %d %d %d",
                                 w_raw, h_raw, algo, mode, arg, gaps);
                if (fields != 6) begin
                    abort_run($sformatf("vector line has %0d fields instead of 6", fields));
                end
                run_frame(w_raw, h_raw, algo, mode, arg, gaps != 0);
                frames_run = frames_run + 1;
            end
        end
        $fclose(fd);
        if (frames_run == 0) begin
            abort_run("the vector file held no frames");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/dither_vectors.txt
# width height algo mode arg gaps, all decimal, one frame per line
# mode 0 random, 1 ramp with step arg, 2 constant arg; gaps 1 pauses spi_cs inside bytes
8 4 0 1 8 0
1 1 0 2 128 0
1 1 0 2 127 0
16 16 3 0 0 0
16 16 7 0 0 0
5 7 1 0 0 0
9 3 2 1 29 0
0 40 2 0 0 0
16 16 1 0 0 1
3 11 3 2 100 1
12 16 2 0 0 1
